/* tb/fib_stimulus.txt */
# tens ones result overflow, all in hex
# result is the four BCD digits of fib(n), overflow is 1 when n > 20
0 0 0000 0
0 1 0001 0
0 2 0001 0
0 3 0002 0
0 5 0005 0
0 7 0013 0
1 0 0055 0
1 2 0144 0
1 5 0610 0
1 7 1597 0
1 9 4181 0
2 0 6765 0
2 1 9999 1
0 4 0003 0
3 0 9999 1
9 9 9999 1
0 6 0008 0
5 5 9999 1
1 1 0089 0
1 3 0233 0
1 4 0377 0
1 6 0987 0

/* sim.f */
verilog/fib_calc_pkg.sv
verilog/bcd_to_bin.sv
verilog/fib_operator.sv
verilog/bin_to_bcd.sv
verilog/fib_sequencer.sv
verilog/fib_bcd_calc.sv
tb/fib_result_checker.sv
tb/tb_fib_bcd_calc.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal -j 0
TOP      = tb_fib_bcd_calc
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb/tb_fib_bcd_calc.sv */
`default_nettype none

module tb_fib_bcd_calc;
    import fib_calc_pkg::*;

    localparam int N_RANDOM = 16;

    logic  i_clk;
    logic  i_rst;
    logic  i_start;
    t_bcd2 i_bcd_in;
    logic  o_ready;
    logic  o_done_tick;
    t_bcd4 o_bcd_out;
    logic  o_overflow;

    logic  exp_strobe;
    t_bcd4 exp_bcd;
    logic  exp_ovf;
    int    value_errors;
    int    other_errors;
    int    results;
    int    seed_ret;
    int    cycles;
    int    cycle_limit = 1000000;                      // Replaced once the cases are known
    logic  load_failed = 1'b0;

    t_bcd2 case_in[$];
    t_bcd4 case_bcd[$];
    logic  case_ovf[$];

    fib_bcd_calc dut
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_bcd_in    (i_bcd_in),
        .o_ready     (o_ready),
        .o_done_tick (o_done_tick),
        .o_bcd_out   (o_bcd_out),
        .o_overflow  (o_overflow)
    );

    fib_result_checker chk
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_start        (i_start),
        .i_ready        (o_ready),
        .i_done_tick    (o_done_tick),
        .i_bcd_out      (o_bcd_out),
        .i_overflow     (o_overflow),
        .i_exp_strobe   (exp_strobe),
        .i_exp_bcd      (exp_bcd),
        .i_exp_ovf      (exp_ovf),
        .o_value_errors (value_errors),
        .o_other_errors (other_errors),
        .o_results      (results)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // ----------------------------------------
    // Expected values and stimulus
    // ----------------------------------------
    function automatic t_bcd4 expected_bcd(input int n);
        int    a;
        int    b;
        int    t;
        int    v;
        t_bcd4 r;
        a = 0;
        b = 1;
        if (n > GEN_MAX)
            v = int'(SAT_VALUE);                       // fib(21) needs five digits
        else if (n == 0)
            v = 0;
        else
        begin
            for (int k = 1; k < n; k++)
            begin
                t = a + b;
                a = b;
                b = t;
            end
            v = b;
        end
        r.thousands = 4'(v / 1000);
        r.hundreds  = 4'((v / 100) % 10);
        r.tens      = 4'((v / 10) % 10);
        r.ones      = 4'(v % 10);
        return r;
    endfunction

    task automatic load_stimulus();
        int          fd;
        string       line;
        logic [3:0]  tens;
        logic [3:0]  ones;
        logic [15:0] result;
        logic        ovf;
        t_bcd2       n_in;
        fd = $fopen("tb/fib_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file tb/fib_stimulus.txt");
            load_failed = 1'b1;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line[0] != "#")
                begin
                    if ($sscanf(line, "%h %h %h %h", tens, ones, result, ovf) == 4)
                    begin
                        n_in.tens = tens;
                        n_in.ones = ones;
                        case_in.push_back(n_in);
                        case_bcd.push_back(result);
                        case_ovf.push_back(ovf);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic add_random_cases();
        int    n;
        t_bcd2 n_in;
        for (int i = 0; i < N_RANDOM; i++)
        begin
            n = int'($urandom_range(99, 0));
            n_in.tens = 4'(n / 10);
            n_in.ones = 4'(n % 10);
            case_in.push_back(n_in);
            case_bcd.push_back(expected_bcd(n));
            case_ovf.push_back(n > GEN_MAX);
        end
    endtask

    // Poke a second start while busy, it must be dropped
    task automatic run_case(input int idx, input logic poke_busy);
        while (!o_ready)
            @(negedge i_clk);
        i_bcd_in   = case_in[idx];
        i_start    = 1'b1;
        exp_strobe = 1'b1;
        exp_bcd    = case_bcd[idx];
        exp_ovf    = case_ovf[idx];
        @(negedge i_clk);
        i_start    = 1'b0;
        exp_strobe = 1'b0;
        if (poke_busy)
        begin
            repeat (3) @(negedge i_clk);
            if (!o_ready)
            begin
                i_bcd_in = '{tens: 4'd9, ones: 4'd9};
                i_start  = 1'b1;
                @(negedge i_clk);
                i_start  = 1'b0;
            end
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial
    begin
        seed_ret   = int'($urandom(32'h6891407f));
        i_rst      = 1'b1;
        i_start    = 1'b0;
        i_bcd_in   = '0;
        exp_strobe = 1'b0;
        exp_bcd    = '0;
        exp_ovf    = 1'b0;
        load_stimulus();
        add_random_cases();
        cycle_limit = case_in.size() * 80 + 100;
        repeat (16) @(negedge i_clk);
        i_rst = 1'b0;
        repeat (2) @(negedge i_clk);
        for (int i = 0; i < case_in.size(); i++)
            run_case(i, (i % 5) == 3);
        while (results < case_in.size())
            @(negedge i_clk);
        repeat (2) @(negedge i_clk);
        $display("Errors: %0d value mismatches, %0d other failures, %0d of %0d results checked",
                 value_errors, other_errors + int'(load_failed), results, case_in.size());
        if (value_errors == 0 && other_errors == 0 && !load_failed)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < cycle_limit)
        begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles with %0d of %0d cases still waiting",
                 cycles, case_in.size() - results, case_in.size());
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/fib_result_checker.sv */
`default_nettype none

module fib_result_checker
(
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_start,
    input  logic                i_ready,
    input  logic                i_done_tick,
    input  fib_calc_pkg::t_bcd4 i_bcd_out,
    input  logic                i_overflow,
    input  logic                i_exp_strobe,
    input  fib_calc_pkg::t_bcd4 i_exp_bcd,
    input  logic                i_exp_ovf,
    output int                  o_value_errors,
    output int                  o_other_errors,
    output int                  o_results
);
    import fib_calc_pkg::*;

    t_bcd4 exp_bcd_q[$];
    logic  exp_ovf_q[$];
    t_bcd4 held_bcd      = '0;                         // Last popped result
    logic  held_ovf      = 1'b0;
    logic  holding       = 1'b0;                       // Between done tick and next start
    logic  busy          = 1'b0;                       // Between accepted start and done tick
    logic  reset_checked = 1'b0;

    initial
    begin
        o_value_errors = 0;
        o_other_errors = 0;
        o_results      = 0;
    end

    task automatic compare_value(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
        if (exp !== act)
        begin
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, act);
            o_value_errors++;
        end
    endtask

    always @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            if (!reset_checked)
            begin
                compare_value("o_overflow", 16'd0, 16'(i_overflow));
                compare_value("o_bcd_out", 16'd0, i_bcd_out);
                reset_checked = 1'b1;
            end
            compare_value("o_ready", busy ? 16'd0 : 16'd1, 16'(i_ready));
            if (i_start && i_ready)
                busy = 1'b1;
            if (i_exp_strobe)
            begin
                exp_bcd_q.push_back(i_exp_bcd);
                exp_ovf_q.push_back(i_exp_ovf);
            end
            if (holding)
            begin
                compare_value("o_bcd_out (held)", held_bcd, i_bcd_out);
                compare_value("o_overflow (held)", 16'(held_ovf), 16'(i_overflow));
                if (i_start && i_ready)
                    holding = 1'b0;                    // Accepted start releases the result
            end
            if (i_done_tick)
            begin
                busy = 1'b0;
                if (exp_bcd_q.size() == 0)
                begin
                    $display("Done tick at %0t with no case waiting for a result", $time);
                    o_other_errors++;
                end
                else
                begin
                    held_bcd = exp_bcd_q.pop_front();
                    held_ovf = exp_ovf_q.pop_front();
                    compare_value("o_bcd_out", held_bcd, i_bcd_out);
                    compare_value("o_overflow", 16'(held_ovf), 16'(i_overflow));
                    holding = 1'b1;
                    o_results++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fib_bcd_calc.sv */
`default_nettype none

module fib_bcd_calc
(
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_start,
    input  fib_calc_pkg::t_bcd2 i_bcd_in,
    output logic                o_ready,
    output logic                o_done_tick,
    output fib_calc_pkg::t_bcd4 o_bcd_out,
    output logic                o_overflow
);
    import fib_calc_pkg::*;

    logic             w_b2b_start;
    logic             w_b2b_done;
    logic             w_fib_start;
    logic             w_fib_done;
    logic             w_fib_overflow;
    logic             w_bcd_start;
    logic             w_bcd_done;
    logic [GEN_W-1:0] w_bin;                           // n in binary
    logic [FIB_W-1:0] w_fib;                           // fib(n) in binary

    fib_sequencer u_seq
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_start        (i_start),
        .o_ready        (o_ready),
        .o_done_tick    (o_done_tick),
        .o_overflow     (o_overflow),
        .o_b2b_start    (w_b2b_start),
        .i_b2b_done     (w_b2b_done),
        .o_fib_start    (w_fib_start),
        .i_fib_done     (w_fib_done),
        .i_fib_overflow (w_fib_overflow),
        .o_bcd_start    (w_bcd_start),
        .i_bcd_done     (w_bcd_done)
    );

    bcd_to_bin u_b2b
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (w_b2b_start),
        .i_bcd       (i_bcd_in),
        .o_done_tick (w_b2b_done),
        .o_bin       (w_bin)
    );

    fib_operator u_fib
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (w_fib_start),
        .i_gen_amt   (w_bin),
        .o_ready     (),                               // Sequencer tracks idle
        .o_done_tick (w_fib_done),
        .o_final     (w_fib),
        .o_overflow  (w_fib_overflow)
    );

    bin_to_bcd u_bcd
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (w_bcd_start),
        .i_bin       (w_fib),
        .o_done_tick (w_bcd_done),
        .o_bcd       (o_bcd_out)
    );

endmodule

`default_nettype wire

/* verilog/fib_sequencer.sv */
`default_nettype none

module fib_sequencer
(
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_start,
    output logic o_ready,
    output logic o_done_tick,
    output logic o_overflow,
    output logic o_b2b_start,
    input  logic i_b2b_done,
    output logic o_fib_start,
    input  logic i_fib_done,
    input  logic i_fib_overflow,
    output logic o_bcd_start,
    input  logic i_bcd_done
);

    typedef enum logic [2:0] {
        e_seq_idle,
        e_seq_conv_in,
        e_seq_compute,
        e_seq_conv_out,
        e_seq_done
    } t_seq_state;

    t_seq_state r_state;
    logic       r_overflow;

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state    <= e_seq_idle;
            r_overflow <= 1'b0;
        end
        else
        begin
            case (r_state)
                e_seq_idle:
                    if (i_start)
                    begin
                        r_state    <= e_seq_conv_in;
                        r_overflow <= 1'b0;              // New n, forget old flag
                    end
                e_seq_conv_in:
                    if (i_b2b_done)
                        r_state <= e_seq_compute;
                e_seq_compute:
                    if (i_fib_done)
                        r_state <= e_seq_conv_out;
                e_seq_conv_out:
                    if (i_bcd_done)
                        r_state <= e_seq_done;
                e_seq_done:
                    r_state <= e_seq_idle;
                default:
                    r_state <= e_seq_idle;
            endcase
            if (i_fib_overflow)
                r_overflow <= 1'b1;
        end
    end

    // Each strobe fires on the transition into the state that waits for it
    assign o_b2b_start = (r_state == e_seq_idle) && i_start;
    assign o_fib_start = (r_state == e_seq_conv_in) && i_b2b_done;
    assign o_bcd_start = (r_state == e_seq_compute) && i_fib_done;

    assign o_ready     = (r_state == e_seq_idle);
    assign o_done_tick = (r_state == e_seq_done);
    assign o_overflow  = r_overflow;

    a_fib_done_in_compute: assert property (@(posedge i_clk) disable iff (i_rst)
        i_fib_done |-> (r_state == e_seq_compute));

endmodule

`default_nettype wire

/* verilog/bin_to_bcd.sv */
`default_nettype none

module bin_to_bcd
(
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_start,
    input  logic [fib_calc_pkg::FIB_W-1:0] i_bin,
    output logic                           o_done_tick,
    output fib_calc_pkg::t_bcd4            o_bcd
);
    import fib_calc_pkg::*;

    typedef enum logic [1:0] {e_dd_idle, e_dd_shift, e_dd_done} t_dd_state;

    localparam int         ACC_W   = $bits(t_bcd4) + FIB_W;
    localparam logic [3:0] SHIFT_N = 4'(FIB_W);

    t_dd_state        r_state;
    logic [3:0]       r_cnt;
    t_bcd4            r_bcd;
    logic [FIB_W-1:0] r_bin;
    t_bcd4            w_adj;
    logic [ACC_W-1:0] w_shift;

    function automatic logic [3:0] f_add3(input logic [3:0] i_digit);
        return (i_digit >= 4'd5) ? i_digit + 4'd3 : i_digit;
    endfunction

    // Correct every digit before it doubles, then shift left
    always_comb
    begin
        w_adj.thousands = f_add3(r_bcd.thousands);
        w_adj.hundreds  = f_add3(r_bcd.hundreds);
        w_adj.tens      = f_add3(r_bcd.tens);
        w_adj.ones      = f_add3(r_bcd.ones);
        w_shift         = {w_adj, r_bin} << 1;
    end

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_dd_idle;
            r_cnt   <= '0;
            r_bcd   <= '0;
        end
        else
        begin
            case (r_state)
                e_dd_idle:
                    if (i_start)
                    begin
                        r_state <= e_dd_shift;
                        r_cnt   <= SHIFT_N;
                        r_bcd   <= '0;
                    end
                e_dd_shift:
                begin
                    r_bcd <= w_shift[ACC_W-1:FIB_W];
                    r_cnt <= r_cnt - 4'd1;
                    if (r_cnt == 4'd1)
                        r_state <= e_dd_done;
                end
                e_dd_done:
                    r_state <= e_dd_idle;
                default:
                    r_state <= e_dd_idle;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (r_state == e_dd_idle && i_start)
            r_bin <= i_bin;
        else if (r_state == e_dd_shift)
            r_bin <= w_shift[FIB_W-1:0];
    end

    assign o_done_tick = (r_state == e_dd_done);
    assign o_bcd       = r_bcd;

    a_digits_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        o_done_tick |-> (o_bcd.thousands <= 4'd9 && o_bcd.hundreds <= 4'd9 &&
                         o_bcd.tens <= 4'd9 && o_bcd.ones <= 4'd9));

endmodule

`default_nettype wire

/* verilog/fib_operator.sv */
`default_nettype none

module fib_operator
(
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_start,
    input  logic [fib_calc_pkg::GEN_W-1:0] i_gen_amt,
    output logic                           o_ready,
    output logic                           o_done_tick,
    output logic [fib_calc_pkg::FIB_W-1:0] o_final,
    output logic                           o_overflow
);
    import fib_calc_pkg::*;

    t_fib_state       r_state, w_state_next;
    logic [FIB_W-1:0] r_temp0, w_temp0_next;           // fib(i-1)
    logic [FIB_W-1:0] r_temp1, w_temp1_next;           // fib(i)
    logic [GEN_W-1:0] r_num, w_num_next;               // Steps left

    // ----------------------------------------
    // State and data registers
    // ----------------------------------------
    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_idle;
            r_temp0 <= '0;
            r_temp1 <= '0;
            r_num   <= '0;
        end
        else
        begin
            r_state <= w_state_next;
            r_temp0 <= w_temp0_next;
            r_temp1 <= w_temp1_next;
            r_num   <= w_num_next;
        end
    end

    // ----------------------------------------
    // Next state and outputs
    // ----------------------------------------
    always_comb
    begin
        w_state_next = r_state;
        w_temp0_next = r_temp0;
        w_temp1_next = r_temp1;
        w_num_next   = r_num;
        o_ready      = 1'b0;
        o_done_tick  = 1'b0;
        o_overflow   = 1'b0;
        o_final      = r_temp1;

        case (r_state)
            e_idle:
            begin
                o_ready = 1'b1;
                if (i_start)
                begin
                    w_temp0_next = '0;
                    w_temp1_next = FIB_W'(1);
                    w_num_next   = i_gen_amt;
                    w_state_next = e_operate;
                    if (i_gen_amt > GEN_MAX)                // Result needs a fifth digit
                    begin
                        w_temp1_next = SAT_VALUE;
                        o_overflow   = 1'b1;
                        w_state_next = e_done;
                    end
                end
            end
            e_operate:
            begin
                if (r_num == '0)
                begin
                    w_temp1_next = '0;                      // fib(0)
                    w_state_next = e_done;
                end
                else if (r_num == GEN_W'(1))
                    w_state_next = e_done;
                else
                begin
                    w_temp1_next = r_temp1 + r_temp0;
                    w_temp0_next = r_temp1;
                    w_num_next   = r_num - GEN_W'(1);
                end
            end
            e_done:
            begin
                o_done_tick  = 1'b1;
                w_state_next = e_idle;
            end
            default:
                w_state_next = e_idle;
        endcase
    end

    a_final_in_range: assert property (@(posedge i_clk) disable iff (i_rst)
        o_done_tick |-> (o_final <= SAT_VALUE));

endmodule

`default_nettype wire

/* verilog/bcd_to_bin.sv */
`default_nettype none

module bcd_to_bin
(
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_start,
    input  fib_calc_pkg::t_bcd2            i_bcd,
    output logic                           o_done_tick,
    output logic [fib_calc_pkg::GEN_W-1:0] o_bin
);
    import fib_calc_pkg::*;

    typedef enum logic [1:0] {e_b2b_idle, e_b2b_shift, e_b2b_done} t_b2b_state;

    localparam logic [3:0] SHIFT_N = 4'd8;              // One shift per BCD bit

    t_b2b_state  r_state;
    logic [3:0]  r_cnt;
    t_bcd2       r_bcd;
    logic [7:0]  r_bin;
    logic [15:0] w_shift;
    t_bcd2       w_bcd_adj;

    // Shift right, then pull every digit of 8 or more back down by 3
    always_comb
    begin
        w_shift   = {r_bcd, r_bin} >> 1;
        w_bcd_adj = w_shift[15:8];
        if (w_bcd_adj.tens >= 4'd8)
            w_bcd_adj.tens = w_bcd_adj.tens - 4'd3;
        if (w_bcd_adj.ones >= 4'd8)
            w_bcd_adj.ones = w_bcd_adj.ones - 4'd3;
    end

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_b2b_idle;
            r_cnt   <= '0;
        end
        else
        begin
            case (r_state)
                e_b2b_idle:
                    if (i_start)
                    begin
                        r_state <= e_b2b_shift;
                        r_cnt   <= SHIFT_N;
                    end
                e_b2b_shift:
                begin
                    r_cnt <= r_cnt - 4'd1;
                    if (r_cnt == 4'd1)
                        r_state <= e_b2b_done;              // Last shift this cycle
                end
                e_b2b_done:
                    r_state <= e_b2b_idle;
                default:
                    r_state <= e_b2b_idle;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (r_state == e_b2b_idle && i_start)
        begin
            r_bcd <= i_bcd;
            r_bin <= '0;
        end
        else if (r_state == e_b2b_shift)
        begin
            r_bcd <= w_bcd_adj;
            r_bin <= w_shift[7:0];
        end
    end

    assign o_done_tick = (r_state == e_b2b_done);
    assign o_bin       = r_bin[GEN_W-1:0];              // Top bit is always zero for n <= 99

    a_no_start_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        (r_state != e_b2b_idle) |-> !i_start);

endmodule

`default_nettype wire

/* verilog/fib_calc_pkg.sv */
`default_nettype none

package fib_calc_pkg;

    // ----------------------------------------
    // Widths and limits
    // ----------------------------------------
    localparam int GEN_W   = 7;                        // Binary n, up to 99
    localparam int FIB_W   = 14;                       // Binary fib(n), up to 9999
    localparam int GEN_MAX = 20;                       // Largest n with a 4 digit result

    localparam logic [FIB_W-1:0] SAT_VALUE = FIB_W'(9999);

    // ----------------------------------------
    // BCD payloads
    // ----------------------------------------
    typedef struct packed {
        logic [3:0] tens;
        logic [3:0] ones;
    } t_bcd2;

    typedef struct packed {
        logic [3:0] thousands;
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } t_bcd4;

    typedef enum logic [1:0] {e_idle, e_operate, e_done} t_fib_state;

endpackage

`default_nettype wire
